// File: source/decodePkg.sv
//***************************************************************************
// Decode stage shared definitions
// Word and register widths, opcode encodings, instruction classes and the
// structs passed between the decode blocks
//***************************************************************************
package decodePkg;

   // Datapath and instruction width
   localparam int WORD_W = 16;

   // Register file geometry
   localparam int REG_COUNT  = 8;
   localparam int REG_ADDR_W = 3;

   // Return address register for JAL and JALR
   localparam logic [REG_ADDR_W-1:0] LINK_REG = 3'd7;

   // Stages after decode where a link instr can still write back
   localparam int LINK_DEPTH = 3;

   // Sequential PC step, one 16-bit instruction
   localparam logic [WORD_W-1:0] PC_INC = 16'd2;

   // Instruction field widths
   localparam int OPCODE_W = 5;
   localparam int IMM8_W   = 8;
   localparam int DISP_W   = 11;

   // Opcodes in bits 15:11
   localparam logic [OPCODE_W-1:0] OP_HALT = 5'b00000;
   localparam logic [OPCODE_W-1:0] OP_J    = 5'b00100;
   localparam logic [OPCODE_W-1:0] OP_JR   = 5'b00101;
   localparam logic [OPCODE_W-1:0] OP_JAL  = 5'b00110;
   localparam logic [OPCODE_W-1:0] OP_JALR = 5'b00111;
   localparam logic [OPCODE_W-1:0] OP_LBI  = 5'b11000;

   // All four conditional branches share the top three opcode bits
   localparam logic [2:0] BR_PREFIX = 3'b011;

   // Instruction classes seen by the decode stage
   typedef enum logic [2:0] {
      NONE,
      BRANCH,
      JUMP_DISP,
      JUMP_REG,
      HALT,
      LBI
   } instrKind_t;

   // Branch condition, straight from bits 12:11
   typedef enum logic [1:0] {
      EQZ,
      NEZ,
      LTZ,
      GEZ
   } brCond_t;

   // Decoded instruction fields
   typedef struct packed {
      instrKind_t              kind;
      logic                    link;
      logic [REG_ADDR_W-1:0]   rs;
      logic [REG_ADDR_W-1:0]   rt;
      brCond_t                 cond;
      logic [WORD_W-1:0]       imm;
   } decodedInstr_t;

   // Register write request
   typedef struct packed {
      logic                    valid;
      logic [REG_ADDR_W-1:0]   addr;
      logic [WORD_W-1:0]       data;
   } wbReq_t;

endpackage

// File: source/instrDecode.sv
//***************************************************************************
// Instruction field decoder
// Splits the instruction word into register fields, classifies the opcode
// and sign extends the immediate for the branch and jump logic
//***************************************************************************
`timescale 1ns/100ps

module instrDecode (
   input  logic [decodePkg::WORD_W-1:0] instr,
   output decodePkg::decodedInstr_t     dec
);
   import decodePkg::*;

   logic [OPCODE_W-1:0] opcode;
   logic [WORD_W-1:0]   imm8Ext;
   logic [WORD_W-1:0]   dispExt;

   assign opcode = instr[WORD_W-1 -: OPCODE_W];

   // I-format 8-bit immediate
   assign imm8Ext = {{(WORD_W-IMM8_W){instr[IMM8_W-1]}}, instr[IMM8_W-1:0]};

   // J-format 11-bit displacement
   assign dispExt = {{(WORD_W-DISP_W){instr[DISP_W-1]}}, instr[DISP_W-1:0]};

   always_comb begin
      dec.kind = NONE;
      dec.link = 1'b0;
      // Register fields are fixed for every format
      dec.rs   = instr[10:8];
      dec.rt   = instr[7:5];
      dec.cond = brCond_t'(instr[12:11]);

      case (opcode)
         OP_HALT: dec.kind = HALT;
         OP_J:    dec.kind = JUMP_DISP;
         OP_JR:   dec.kind = JUMP_REG;
         OP_JAL: begin
            dec.kind = JUMP_DISP;
            dec.link = 1'b1;
         end
         OP_JALR: begin
            dec.kind = JUMP_REG;
            dec.link = 1'b1;
         end
         // Only classified here, the write is done in writeback
         OP_LBI:  dec.kind = LBI;
         default: begin
            // BEQZ, BNEZ, BLTZ, BGEZ
            if (opcode[OPCODE_W-1 -: 3] == BR_PREFIX) begin
               dec.kind = BRANCH;
            end
         end
      endcase

      // Displacement jumps use the long field
      if (dec.kind == JUMP_DISP) begin
         dec.imm = dispExt;
      end else begin
         dec.imm = imm8Ext;
      end
   end

endmodule

// File: source/regFile.sv
//***************************************************************************
// General register file
// Eight 16-bit registers, two combinational read ports and one write port
// Writes land at the clock edge with no write-to-read bypass
//***************************************************************************
`timescale 1ns/100ps

module regFile (
   input  logic                             clk,
   input  logic                             rst,
   input  logic [decodePkg::REG_ADDR_W-1:0] rdAddr1,
   input  logic [decodePkg::REG_ADDR_W-1:0] rdAddr2,
   input  decodePkg::wbReq_t                wr,
   output logic [decodePkg::WORD_W-1:0]     rdData1,
   output logic [decodePkg::WORD_W-1:0]     rdData2
);
   import decodePkg::*;

   // Register array
   logic [WORD_W-1:0] regs [REG_COUNT];

   // Single write port
   always_ff @(posedge clk) begin
      if (rst) begin
         // All registers read zero after reset
         for (int i = 0; i < REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wr.valid) begin
         regs[wr.addr] <= wr.data;
      end
   end

   // Read ports show the old value in the write cycle
   assign rdData1 = regs[rdAddr1];
   assign rdData2 = regs[rdAddr2];

   // Arbitrated write from linkTracker must be fully known
   wrKnownA: assert property (
      @(posedge clk) disable iff (rst)
      wr.valid |-> !$isunknown({wr.addr, wr.data})
   ) else $error("regFile: valid write with unknown address or data");

endmodule

// File: source/linkTracker.sv
//***************************************************************************
// Link instruction tracker
// Writes the JAL/JALR return address at decode and follows the link
// instruction down three stages to block its late writeback
//***************************************************************************
`timescale 1ns/100ps

module linkTracker (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         instrValid,
   input  decodePkg::decodedInstr_t     dec,
   input  logic [decodePkg::WORD_W-1:0] pc,
   input  decodePkg::wbReq_t            wb,
   output decodePkg::wbReq_t            regWr
);
   import decodePkg::*;

   logic                  linkNow;
   logic [LINK_DEPTH-1:0] linkStages;
   logic                  wbBlocked;

   // Link instruction in decode this cycle
   assign linkNow = instrValid & dec.link;

   // Bit 0 is execute and the top bit is writeback
   always_ff @(posedge clk) begin
      if (rst) begin
         linkStages <= '0;
      end else begin
         linkStages <= {linkStages[LINK_DEPTH-2:0], linkNow};
      end
   end

   // Writeback in any of these stages may be the link instr itself
   assign wbBlocked = |linkStages;

   // Write port arbitration
   always_comb begin
      regWr = wb;
      if (linkNow) begin
         // Link write wins over a same-cycle external write
         regWr.valid = 1'b1;
         regWr.addr  = LINK_REG;
         regWr.data  = pc + PC_INC;
      end else if (wbBlocked) begin
         regWr.valid = 1'b0;
      end
   end

   // While a link instr is still in flight only a new link decode writes r7
   linkSrcA: assert property (
      @(posedge clk) disable iff (rst)
      linkNow |=> (!(regWr.valid && regWr.addr == LINK_REG) || linkNow)[*LINK_DEPTH]
   ) else $error("linkTracker: link register written while link writeback pending");

endmodule

// File: source/branchUnit.sv
//***************************************************************************
// Branch and jump resolution
// Evaluates branch conditions on the rs value, selects the next PC in the
// decode cycle and registers the redirect as a fetch/decode flush
//***************************************************************************
`timescale 1ns/100ps

module branchUnit (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         instrValid,
   input  decodePkg::decodedInstr_t     dec,
   input  logic [decodePkg::WORD_W-1:0] pc,
   input  logic [decodePkg::WORD_W-1:0] rsData,
   output logic                         pcSel,
   output logic [decodePkg::WORD_W-1:0] nextPc,
   output logic                         branchTaken
);
   import decodePkg::*;

   logic              condMet;
   logic              taken;
   logic [WORD_W-1:0] pcPlus2;
   logic [WORD_W-1:0] target;

   // Fall-through address
   assign pcPlus2 = pc + PC_INC;

   // Zero test or sign bit of rs
   always_comb begin
      condMet = 1'b0;
      case (dec.cond)
         EQZ: condMet = (rsData == '0);
         NEZ: condMet = (rsData != '0);
         LTZ: condMet = rsData[WORD_W-1];
         GEZ: condMet = ~rsData[WORD_W-1];
         default: condMet = 1'b0;
      endcase
   end

   // Taken decision and target per class
   always_comb begin
      taken  = 1'b0;
      // PC-relative for branches and J/JAL
      target = pcPlus2 + dec.imm;
      case (dec.kind)
         BRANCH:    taken = condMet;
         JUMP_DISP: taken = 1'b1;
         JUMP_REG: begin
            taken  = 1'b1;
            target = rsData + dec.imm;
         end
         // HALT, LBI and NONE fall through
         default:   taken = 1'b0;
      endcase
   end

   assign pcSel  = instrValid & taken;
   assign nextPc = pcSel ? target : pcPlus2;

   // Flush request for the fetch/decode register
   always_ff @(posedge clk) begin
      if (rst) begin
         branchTaken <= 1'b0;
      end else begin
         branchTaken <= pcSel;
      end
   end

   // A flush only follows a valid branch or jump
   flushSrcA: assert property (
      @(posedge clk) disable iff (rst)
      branchTaken |-> $past(instrValid) &&
         ($past(dec.kind) inside {BRANCH, JUMP_DISP, JUMP_REG})
   ) else $error("branchUnit: flush without a valid branch or jump");

endmodule

// File: source/decodeStage.sv
//***************************************************************************
// Decode stage top level
// Connects instruction decode, register file, link tracking and branch
// resolution for the five-stage pipeline
//***************************************************************************
`timescale 1ns/100ps

module decodeStage (
   input  logic                         clk,
   input  logic                         rst,
   input  logic [decodePkg::WORD_W-1:0] instr,
   input  logic [decodePkg::WORD_W-1:0] pc,
   input  logic                         instrValid,
   input  decodePkg::wbReq_t            wb,
   output logic [decodePkg::WORD_W-1:0] reg1Data,
   output logic [decodePkg::WORD_W-1:0] reg2Data,
   output logic                         pcSel,
   output logic [decodePkg::WORD_W-1:0] nextPc,
   output logic                         branchTaken
);
   import decodePkg::*;

   decodedInstr_t dec;
   // Arbitrated register write
   wbReq_t        regWr;

   instrDecode instrDecode0 (
      .instr (instr),
      .dec   (dec)
   );

   // rs feeds both the top output and the branch logic
   regFile regFile0 (
      .clk     (clk),
      .rst     (rst),
      .rdAddr1 (dec.rs),
      .rdAddr2 (dec.rt),
      .wr      (regWr),
      .rdData1 (reg1Data),
      .rdData2 (reg2Data)
   );

   linkTracker linkTracker0 (
      .clk        (clk),
      .rst        (rst),
      .instrValid (instrValid),
      .dec        (dec),
      .pc         (pc),
      .wb         (wb),
      .regWr      (regWr)
   );

   branchUnit branchUnit0 (
      .clk         (clk),
      .rst         (rst),
      .instrValid  (instrValid),
      .dec         (dec),
      .pc          (pc),
      .rsData      (reg1Data),
      .pcSel       (pcSel),
      .nextPc      (nextPc),
      .branchTaken (branchTaken)
   );

endmodule

// File: sim/decodeStage_tb.sv
//***************************************************************************
// Decode stage testbench
// Table of instructions and writeback requests applied one per cycle, with
// expected register reads and redirects taken from a register model
//***************************************************************************
`timescale 1ns/100ps

module decodeStage_tb;
   import decodePkg::*;

   localparam int          CLK_HALF   = 20;
   localparam int          RST_CYCLES = 5;
   localparam int          ROW_MAX    = 128;
   localparam int          WAIT_MAX   = 20;
   localparam logic [31:0] LFSR_SEED  = 32'hfa9;
   // x^32 + x^22 + x^2 + x + 1
   localparam logic [31:0] LFSR_TAPS  = 32'h80200003;

   // One cycle of stimulus with its expected responses
   typedef struct packed {
      logic [WORD_W-1:0] instr;
      logic [WORD_W-1:0] pc;
      logic              valid;
      wbReq_t            wb;
      logic [WORD_W-1:0] expReg1;
      logic [WORD_W-1:0] expReg2;
      logic              expPcSel;
      logic [WORD_W-1:0] expNextPc;
   } stimRow_t;

   logic              clk;
   logic              rst;
   logic [WORD_W-1:0] instr;
   logic [WORD_W-1:0] pc;
   logic              instrValid;
   wbReq_t            wb;
   logic [WORD_W-1:0] reg1Data;
   logic [WORD_W-1:0] reg2Data;
   logic              pcSel;
   logic [WORD_W-1:0] nextPc;
   logic              branchTaken;

   stimRow_t              rows [ROW_MAX];
   int                    rowCount;
   // Reference register contents and link history
   logic [WORD_W-1:0]     modelRegs [REG_COUNT];
   logic [LINK_DEPTH-1:0] linkHist;
   logic [31:0]           lfsrState;
   logic                  prevSel;
   int                    waitCount;

   decodeStage dut0 (
      .clk         (clk),
      .rst         (rst),
      .instr       (instr),
      .pc          (pc),
      .instrValid  (instrValid),
      .wb          (wb),
      .reg1Data    (reg1Data),
      .reg2Data    (reg2Data),
      .pcSel       (pcSel),
      .nextPc      (nextPc),
      .branchTaken (branchTaken)
   );

   always #CLK_HALF clk = ~clk;

   // Galois LFSR, one step per bit
   function automatic logic [31:0] lfsrNext(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ LFSR_TAPS;
      end
      return n;
   endfunction

   task automatic takeBits(input int n, output logic [WORD_W-1:0] w);
      w = '0;
      for (int b = 0; b < n; b++) begin
         w = {w[WORD_W-2:0], lfsrState[0]};
         lfsrState = lfsrNext(lfsrState);
      end
   endtask

   function automatic logic [WORD_W-1:0] sext8(input logic [7:0] v);
      return {{8{v[7]}}, v};
   endfunction

   function automatic logic [WORD_W-1:0] sext11(input logic [10:0] v);
      return {{5{v[10]}}, v};
   endfunction

   // Unlisted opcode, only the register fields matter
   function automatic logic [WORD_W-1:0] makeNop(input logic [2:0] rs, input logic [2:0] rt);
      return {5'b00001, rs, rt, 5'b00000};
   endfunction

   // Expected redirect from opcode, condition and the rs value
   task automatic predictRedirect(input logic [WORD_W-1:0] ins, input logic [WORD_W-1:0] pcVal,
                                  input logic valid, input logic [WORD_W-1:0] rsVal,
                                  output logic sel, output logic [WORD_W-1:0] next);
      logic [4:0]        opc;
      logic              tk;
      logic [WORD_W-1:0] tgt;
      opc = ins[15:11];
      tk  = 1'b0;
      tgt = pcVal + 16'd2 + sext8(ins[7:0]);
      if (opc == OP_J || opc == OP_JAL) begin
         tk  = 1'b1;
         tgt = pcVal + 16'd2 + sext11(ins[10:0]);
      end else if (opc == OP_JR || opc == OP_JALR) begin
         tk  = 1'b1;
         tgt = rsVal + sext8(ins[7:0]);
      end else if (opc[4:2] == BR_PREFIX) begin
         case (ins[12:11])
            2'b00: tk = (rsVal == 16'd0);
            2'b01: tk = (rsVal != 16'd0);
            2'b10: tk = rsVal[15];
            default: tk = !rsVal[15];
         endcase
      end
      sel  = valid && tk;
      next = sel ? tgt : pcVal + 16'd2;
   endtask

   // Append a row, then apply its write to the model
   task automatic addRow(input logic [WORD_W-1:0] ins, input logic [WORD_W-1:0] pcVal,
                         input logic valid, input logic wbValid, input logic [2:0] wbAddr,
                         input logic [WORD_W-1:0] wbData);
      stimRow_t r;
      logic     linkNow;
      r.instr       = ins;
      r.pc          = pcVal;
      r.valid       = valid;
      r.wb.valid    = wbValid;
      r.wb.addr     = wbAddr;
      r.wb.data     = wbData;
      r.expReg1     = modelRegs[ins[10:8]];
      r.expReg2     = modelRegs[ins[7:5]];
      predictRedirect(ins, pcVal, valid, modelRegs[ins[10:8]], r.expPcSel, r.expNextPc);
      rows[rowCount] = r;
      rowCount++;
      linkNow = valid && (ins[15:11] == OP_JAL || ins[15:11] == OP_JALR);
      // Link write wins, external write blocked behind a link
      if (linkNow) begin
         modelRegs[LINK_REG] = pcVal + 16'd2;
      end else if (wbValid && linkHist == '0) begin
         modelRegs[wbAddr] = wbData;
      end
      linkHist = {linkHist[LINK_DEPTH-2:0], linkNow};
   endtask

   task automatic buildTable();
      logic [WORD_W-1:0] w;
      logic [WORD_W-1:0] p;
      logic [WORD_W-1:0] posVal;
      logic [WORD_W-1:0] negVal;
      // Every register reads zero after reset
      for (int r = 0; r < REG_COUNT; r += 2) begin
         addRow(makeNop(r[2:0], r[2:0] + 3'd1), 16'h0100, 1'b1, 1'b0, 3'd0, '0);
      end
      // Write then read back on both ports
      for (int r = 1; r < REG_COUNT; r++) begin
         takeBits(16, w);
         addRow(makeNop(r[2:0], r[2:0]), 16'h0200, 1'b1, 1'b1, r[2:0], w);
         addRow(makeNop(r[2:0], r[2:0]), 16'h0202, 1'b1, 1'b0, 3'd0, '0);
      end
      // r1 zero, r2 positive, r3 negative
      takeBits(15, w);
      posVal = {1'b0, w[14:1], 1'b1};
      takeBits(15, w);
      negVal = {1'b1, w[14:0]};
      addRow(makeNop(3'd1, 3'd2), 16'h0300, 1'b1, 1'b1, 3'd1, '0);
      addRow(makeNop(3'd1, 3'd2), 16'h0302, 1'b1, 1'b1, 3'd2, posVal);
      addRow(makeNop(3'd2, 3'd3), 16'h0304, 1'b1, 1'b1, 3'd3, negVal);
      // All four conditions on each value, back to back
      for (int c = 0; c < 4; c++) begin
         for (int r = 1; r <= 3; r++) begin
            takeBits(8, w);
            takeBits(15, p);
            addRow({BR_PREFIX, c[1:0], r[2:0], w[7:0]}, {p[14:0], 1'b0}, 1'b1, 1'b0, 3'd0, '0);
         end
      end
      // Jumps, then classes that never redirect
      takeBits(11, w);
      addRow({OP_J, w[10:0]}, 16'h4000, 1'b1, 1'b0, 3'd0, '0);
      takeBits(8, w);
      addRow({OP_JR, 3'd2, w[7:0]}, 16'h4002, 1'b1, 1'b0, 3'd0, '0);
      takeBits(8, w);
      addRow({OP_JR, 3'd3, w[7:0]}, 16'h4004, 1'b1, 1'b0, 3'd0, '0);
      addRow({OP_HALT, 11'd0}, 16'h4006, 1'b1, 1'b0, 3'd0, '0);
      addRow({OP_LBI, 3'd1, 8'h80}, 16'h4008, 1'b1, 1'b0, 3'd0, '0);
      // Would redirect if valid
      addRow({OP_J, 11'h123}, 16'h400a, 1'b0, 1'b0, 3'd0, '0);
      addRow({BR_PREFIX, 2'b00, 3'd1, 8'h10}, 16'h400c, 1'b0, 1'b0, 3'd0, '0);
      // JAL, three blocked writes to r4, fourth accepted
      takeBits(11, w);
      addRow({OP_JAL, w[10:0]}, 16'h2000, 1'b1, 1'b0, 3'd0, '0);
      for (int k = 0; k < 4; k++) begin
         takeBits(16, w);
         addRow(makeNop(3'd7, 3'd4), 16'h2100, 1'b1, 1'b1, 3'd4, w);
      end
      addRow(makeNop(3'd4, 3'd7), 16'h2102, 1'b1, 1'b0, 3'd0, '0);
      // JALR with a same-cycle write to r5
      takeBits(8, w);
      takeBits(16, p);
      addRow({OP_JALR, 3'd2, w[7:0]}, 16'h3000, 1'b1, 1'b1, 3'd5, p);
      for (int k = 0; k < 4; k++) begin
         addRow(makeNop(3'd5, 3'd7), 16'h3100, 1'b1, 1'b0, 3'd0, '0);
      end
   endtask

   task automatic checkValue(input logic [WORD_W-1:0] got, input logic [WORD_W-1:0] exp,
                             input string what);
      if (got !== exp) begin
         $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
         $display("TEST FAILED");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   initial begin
      clk        = 1'b0;
      rst        = 1'b1;
      instr      = makeNop(3'd0, 3'd0);
      pc         = '0;
      instrValid = 1'b0;
      wb         = '0;
      rowCount   = 0;
      linkHist   = '0;
      prevSel    = 1'b0;
      lfsrState  = LFSR_SEED;
      for (int r = 0; r < REG_COUNT; r++) begin
         modelRegs[r] = '0;
      end
      buildTable();

      repeat (RST_CYCLES) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      // Flush request must be clear once out of reset
      waitCount = 0;
      while (branchTaken !== 1'b0) begin
         if (waitCount == WAIT_MAX) begin
            $display("TEST FAILED");
            $fatal(1, "Timed out waiting for branchTaken to clear after reset");
         end else begin
            waitCount++;
            @(negedge clk);
         end
      end

      for (int i = 0; i < rowCount; i++) begin
         @(posedge clk);
         instr      <= rows[i].instr;
         pc         <= rows[i].pc;
         instrValid <= rows[i].valid;
         wb         <= rows[i].wb;
         @(negedge clk);
         checkValue(reg1Data, rows[i].expReg1, $sformatf("row %0d reg1Data", i));
         checkValue(reg2Data, rows[i].expReg2, $sformatf("row %0d reg2Data", i));
         checkValue({15'd0, pcSel}, {15'd0, rows[i].expPcSel}, $sformatf("row %0d pcSel", i));
         checkValue(nextPc, rows[i].expNextPc, $sformatf("row %0d nextPc", i));
         // Flush follows the previous row's redirect
         checkValue({15'd0, branchTaken}, {15'd0, prevSel}, $sformatf("row %0d branchTaken", i));
         prevSel = rows[i].expPcSel;
      end

      $display("TEST OK");
      $finish;
   end

endmodule

// File: all.f
source/decodePkg.sv
source/instrDecode.sv
source/regFile.sv
source/linkTracker.sv
source/branchUnit.sv
source/decodeStage.sv
sim/decodeStage_tb.sv
